// File: cache/axil_req_hold.sv
`timescale 1ns/10ps

module axil_req_hold #(
  parameter type payload_t = logic
) (
  input  logic     ACLK,
  input  logic     ARESETn,
  input  logic     load,
  input  payload_t load_data,
  input  logic     ready,
  output logic     valid,
  output payload_t data
);

  // Valid holds until the subordinate takes the request
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (valid && ready) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge ACLK) begin
    if (load) begin
      data <= load_data;
    end
  end

endmodule

// File: cache/cache_ctrl.sv
`timescale 1ns/10ps
`include "axil_macros.svh"

module cache_ctrl (
  input  logic                 ACLK,
  input  logic                 ARESETn,
  // Processor side
  input  logic                 ar_valid,
  output logic                 ar_ready,
  input  axil_pkg::axil_addr_t ar,
  output logic                 r_valid,
  input  logic                 r_ready,
  output axil_pkg::axil_data_t r_data,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  axil_pkg::axil_addr_t aw,
  input  logic                 w_valid,
  output logic                 w_ready,
  input  axil_pkg::axil_wr_t   w,
  output logic                 b_valid,
  input  logic                 b_ready,
  // Cache arrays
  output axil_pkg::axil_addr_t lookup_addr,
  input  logic                 hit,
  input  axil_pkg::axil_data_t rd_data,
  input  logic                 victim_dirty,
  input  axil_pkg::axil_addr_t victim_addr,
  output axil_pkg::store_upd_t upd,
  // Memory side
  output logic                 mem_ar_valid,
  output axil_pkg::axil_addr_t mem_ar,
  input  logic                 mem_ar_ready,
  input  logic                 mem_r_valid,
  input  axil_pkg::axil_data_t mem_r_data,
  output logic                 mem_r_ready,
  output logic                 mem_aw_valid,
  output axil_pkg::axil_addr_t mem_aw,
  input  logic                 mem_aw_ready,
  output logic                 mem_w_valid,
  output axil_pkg::axil_wr_t   mem_w,
  input  logic                 mem_w_ready,
  input  logic                 mem_b_valid,
  output logic                 mem_b_ready
);

  axil_pkg::ctrl_state_e state_q;
  axil_pkg::ctrl_state_e state_d;

  logic                  req_ready_q;
  logic                  rd_pend_q;
  logic                  req_is_wr_q;
  axil_pkg::axil_addr_t  req_addr_q;
  axil_pkg::axil_wr_t    req_wr_q;

  logic ar_take;
  logic wr_take;
  logic r_take;
  logic b_take;
  logic rd_lookup;
  logic wr_lookup;
  logic miss;
  logic wb_load;
  logic ar_load;
  logic wb_done;
  logic fill_done;

  axil_pkg::cache_addr_t look;
  axil_pkg::axil_wr_t    victim_wr;
  axil_pkg::axil_data_t  fill_word;

  // One transaction at a time, so all request channels share one ready
  assign ar_ready = req_ready_q;
  assign aw_ready = req_ready_q;
  assign w_ready  = req_ready_q;

  assign ar_take = ar_valid && ar_ready;
  assign wr_take = aw_valid && aw_ready && w_valid && w_ready;
  assign r_take  = r_valid && r_ready;
  assign b_take  = b_valid && b_ready;

  // Writes are looked up in the transfer cycle, reads one cycle later
  assign rd_lookup = (state_q == axil_pkg::ST_READY) && rd_pend_q;
  assign wr_lookup = (state_q == axil_pkg::ST_READY) && wr_take;
  assign miss      = (rd_lookup || wr_lookup) && !hit;

  assign lookup_addr = (state_q == axil_pkg::ST_READY && !rd_pend_q) ? aw : req_addr_q;
  assign look        = lookup_addr;

  assign mem_b_ready = (state_q == axil_pkg::ST_AWAIT_WB);
  assign mem_r_ready = (state_q == axil_pkg::ST_AWAIT_FILL);
  assign wb_done     = mem_b_ready && mem_b_valid;
  assign fill_done   = mem_r_ready && mem_r_valid;

  // Dirty victim goes out first, the fill follows its B response
  assign wb_load = miss && victim_dirty;
  assign ar_load = (miss && !victim_dirty) || wb_done;

  assign victim_wr.data = rd_data;
  assign victim_wr.strb = `STRB_ALL;

  // Write miss folds the pending bytes into the incoming block
  assign fill_word = req_is_wr_q ?
                     axil_pkg::strb_merge(mem_r_data, req_wr_q.data, req_wr_q.strb) :
                     mem_r_data;

  always_comb begin
    upd       = '0;
    upd.index = look.index;
    upd.tag   = look.tag;
    if (wr_lookup && hit) begin
      upd.en         = 1'b1;
      upd.data       = w.data;
      upd.strb       = w.strb;
      upd.mark_dirty = 1'b1;
    end else if (fill_done) begin
      upd.en         = 1'b1;
      upd.fill       = 1'b1;
      upd.data       = fill_word;
      upd.strb       = `STRB_ALL;
      upd.mark_dirty = req_is_wr_q;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      axil_pkg::ST_READY: begin
        if (rd_lookup || wr_lookup) begin
          if (hit) begin
            state_d = axil_pkg::ST_AWAIT_MGR;
          end else if (victim_dirty) begin
            state_d = axil_pkg::ST_AWAIT_WB;
          end else begin
            state_d = axil_pkg::ST_AWAIT_FILL;
          end
        end
      end
      axil_pkg::ST_AWAIT_WB: begin
        if (wb_done) begin
          state_d = axil_pkg::ST_AWAIT_FILL;
        end
      end
      axil_pkg::ST_AWAIT_FILL: begin
        if (fill_done) begin
          state_d = axil_pkg::ST_AWAIT_MGR;
        end
      end
      default: begin
        if (r_take || b_take) begin
          state_d = axil_pkg::ST_READY;
        end
      end
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state_q     <= axil_pkg::ST_READY;
      req_ready_q <= 1'b1;
      rd_pend_q   <= 1'b0;
      req_is_wr_q <= 1'b0;
      r_valid     <= 1'b0;
      b_valid     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ar_take || wr_take) begin
        req_ready_q <= 1'b0;
      end else if (r_take || b_take) begin
        req_ready_q <= 1'b1;
      end
      if (ar_take) begin
        rd_pend_q <= 1'b1;
      end else if (rd_lookup) begin
        rd_pend_q <= 1'b0;
      end
      if (ar_take) begin
        req_is_wr_q <= 1'b0;
      end else if (wr_take) begin
        req_is_wr_q <= 1'b1;
      end
      if ((rd_lookup && hit) || (fill_done && !req_is_wr_q)) begin
        r_valid <= 1'b1;
      end else if (r_take) begin
        r_valid <= 1'b0;
      end
      if ((wr_lookup && hit) || (fill_done && req_is_wr_q)) begin
        b_valid <= 1'b1;
      end else if (b_take) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (ar_take) begin
      req_addr_q <= ar;
    end else if (wr_take) begin
      req_addr_q <= aw;
    end
    if (wr_take) begin
      req_wr_q <= w;
    end
    if (rd_lookup && hit) begin
      r_data <= rd_data;
    end else if (fill_done) begin
      r_data <= mem_r_data;
    end
  end

  axil_req_hold #(.payload_t(axil_pkg::axil_addr_t)) mem_ar_hold_i (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .load      (ar_load),
    .load_data (lookup_addr),
    .ready     (mem_ar_ready),
    .valid     (mem_ar_valid),
    .data      (mem_ar)
  );

  axil_req_hold #(.payload_t(axil_pkg::axil_addr_t)) mem_aw_hold_i (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .load      (wb_load),
    .load_data (victim_addr),
    .ready     (mem_aw_ready),
    .valid     (mem_aw_valid),
    .data      (mem_aw)
  );

  axil_req_hold #(.payload_t(axil_pkg::axil_wr_t)) mem_w_hold_i (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .load      (wb_load),
    .load_data (victim_wr),
    .ready     (mem_w_ready),
    .valid     (mem_w_valid),
    .data      (mem_w)
  );

endmodule

// File: cache/cache_store.sv
`timescale 1ns/10ps
`include "axil_macros.svh"

module cache_store #(
  parameter int num_sets = `CACHE_SETS
) (
  input  logic                 ACLK,
  input  logic                 ARESETn,
  input  axil_pkg::axil_addr_t lookup_addr,
  output logic                 hit,
  output axil_pkg::axil_data_t rd_data,
  output logic                 victim_dirty,
  output axil_pkg::axil_addr_t victim_addr,
  input  axil_pkg::store_upd_t upd
);

  axil_pkg::cache_tag_t  tag_mem [num_sets];
  axil_pkg::axil_data_t  data_mem [num_sets];
  logic [num_sets-1:0]   valid_q;
  logic [num_sets-1:0]   dirty_q;

  axil_pkg::cache_addr_t look;
  axil_pkg::cache_addr_t victim;
  axil_pkg::axil_data_t  new_word;

  assign look = lookup_addr;

  // Lookup of the set selected by the request address
  assign hit          = valid_q[look.index] && (tag_mem[look.index] == look.tag);
  assign rd_data      = data_mem[look.index];
  assign victim_dirty = valid_q[look.index] && dirty_q[look.index];

  // Block address of whatever currently occupies the set
  always_comb begin
    victim        = '0;
    victim.tag    = tag_mem[look.index];
    victim.index  = look.index;
    victim_addr   = victim;
  end

  // A fill replaces the word, a hit update merges under the strobe
  always_comb begin
    if (upd.fill) begin
      new_word = upd.data;
    end else begin
      new_word = axil_pkg::strb_merge(data_mem[upd.index], upd.data, upd.strb);
    end
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (upd.en) begin
      if (upd.fill) begin
        valid_q[upd.index] <= 1'b1;
        // Fresh block is clean unless a pending write lands in it
        dirty_q[upd.index] <= upd.mark_dirty;
      end else if (upd.mark_dirty) begin
        dirty_q[upd.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (upd.en) begin
      data_mem[upd.index] <= new_word;
      if (upd.fill) begin
        tag_mem[upd.index] <= upd.tag;
      end
    end
  end

endmodule

// File: common/axil_macros.svh
`ifndef AXIL_MACROS_SVH
`define AXIL_MACROS_SVH

// AXI-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// Direct-mapped cache geometry, one word per block
`define CACHE_SETS 4
`define CACHE_OFFSET_W 2

// Backing memory depth in words
`define MEM_WORDS 1024

// Every byte lane enabled
`define STRB_ALL {`AXIL_STRB_W{1'b1}}

`endif

// File: common/axil_pkg.sv
`include "axil_macros.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;

  // W channel payload
  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_wr_t;

  typedef logic [$clog2(`CACHE_SETS)-1:0] cache_index_t;
  typedef logic [`AXIL_ADDR_W-$clog2(`CACHE_SETS)-`CACHE_OFFSET_W-1:0] cache_tag_t;

  // Byte address seen as tag, set index and byte offset
  typedef struct packed {
    cache_tag_t                  tag;
    cache_index_t                index;
    logic [`CACHE_OFFSET_W-1:0]  offset;
  } cache_addr_t;

  // One write into the cache arrays
  typedef struct packed {
    logic         en;
    cache_index_t index;
    cache_tag_t   tag;
    axil_data_t   data;
    axil_strb_t   strb;
    logic         fill;
    logic         mark_dirty;
  } store_upd_t;

  typedef enum logic [1:0] {
    ST_READY,
    ST_AWAIT_WB,
    ST_AWAIT_FILL,
    ST_AWAIT_MGR
  } ctrl_state_e;

  // Replace the bytes of old_word whose strobe bit is set
  function automatic axil_data_t strb_merge(axil_data_t old_word, axil_data_t new_word,
                                            axil_strb_t strb);
    axil_data_t result;
    result = old_word;
    for (int i = 0; i < `AXIL_STRB_W; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

endpackage

// File: hdl/cache_system.sv
`timescale 1ns/10ps
`include "axil_macros.svh"

module cache_system (
  input  logic                 ACLK,
  input  logic                 ARESETn,
  input  logic                 ar_valid,
  output logic                 ar_ready,
  input  axil_pkg::axil_addr_t ar,
  output logic                 r_valid,
  input  logic                 r_ready,
  output axil_pkg::axil_data_t r_data,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  axil_pkg::axil_addr_t aw,
  input  logic                 w_valid,
  output logic                 w_ready,
  input  axil_pkg::axil_wr_t   w,
  output logic                 b_valid,
  input  logic                 b_ready
);

  // Controller to cache arrays
  axil_pkg::axil_addr_t lookup_addr;
  logic                 hit;
  axil_pkg::axil_data_t rd_data;
  logic                 victim_dirty;
  axil_pkg::axil_addr_t victim_addr;
  axil_pkg::store_upd_t upd;

  // Controller to backing memory
  logic                 mem_ar_valid;
  axil_pkg::axil_addr_t mem_ar;
  logic                 mem_ar_ready;
  logic                 mem_r_valid;
  axil_pkg::axil_data_t mem_r_data;
  logic                 mem_r_ready;
  logic                 mem_aw_valid;
  axil_pkg::axil_addr_t mem_aw;
  logic                 mem_aw_ready;
  logic                 mem_w_valid;
  axil_pkg::axil_wr_t   mem_w;
  logic                 mem_w_ready;
  logic                 mem_b_valid;
  logic                 mem_b_ready;

  cache_ctrl cache_ctrl_i (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar           (ar),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r_data       (r_data),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .aw           (aw),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .w            (w),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .lookup_addr  (lookup_addr),
    .hit          (hit),
    .rd_data      (rd_data),
    .victim_dirty (victim_dirty),
    .victim_addr  (victim_addr),
    .upd          (upd),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar       (mem_ar),
    .mem_ar_ready (mem_ar_ready),
    .mem_r_valid  (mem_r_valid),
    .mem_r_data   (mem_r_data),
    .mem_r_ready  (mem_r_ready),
    .mem_aw_valid (mem_aw_valid),
    .mem_aw       (mem_aw),
    .mem_aw_ready (mem_aw_ready),
    .mem_w_valid  (mem_w_valid),
    .mem_w        (mem_w),
    .mem_w_ready  (mem_w_ready),
    .mem_b_valid  (mem_b_valid),
    .mem_b_ready  (mem_b_ready)
  );

  cache_store #(.num_sets(`CACHE_SETS)) cache_store_i (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .lookup_addr  (lookup_addr),
    .hit          (hit),
    .rd_data      (rd_data),
    .victim_dirty (victim_dirty),
    .victim_addr  (victim_addr),
    .upd          (upd)
  );

  axil_memory #(.mem_words(`MEM_WORDS)) axil_memory_i (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .ar_valid (mem_ar_valid),
    .ar       (mem_ar),
    .ar_ready (mem_ar_ready),
    .r_valid  (mem_r_valid),
    .r_data   (mem_r_data),
    .r_ready  (mem_r_ready),
    .aw_valid (mem_aw_valid),
    .aw       (mem_aw),
    .aw_ready (mem_aw_ready),
    .w_valid  (mem_w_valid),
    .w        (mem_w),
    .w_ready  (mem_w_ready),
    .b_valid  (mem_b_valid),
    .b_ready  (mem_b_ready)
  );

endmodule

// File: mem/axil_memory.sv
`timescale 1ns/10ps
`include "axil_macros.svh"

module axil_memory #(
  parameter int mem_words = `MEM_WORDS
) (
  input  logic                 ACLK,
  input  logic                 ARESETn,
  input  logic                 ar_valid,
  input  axil_pkg::axil_addr_t ar,
  output logic                 ar_ready,
  output logic                 r_valid,
  output axil_pkg::axil_data_t r_data,
  input  logic                 r_ready,
  input  logic                 aw_valid,
  input  axil_pkg::axil_addr_t aw,
  output logic                 aw_ready,
  input  logic                 w_valid,
  input  axil_pkg::axil_wr_t   w,
  output logic                 w_ready,
  output logic                 b_valid,
  input  logic                 b_ready
);

  localparam int idx_w = $clog2(mem_words);

  axil_pkg::axil_data_t mem_q [mem_words];

  logic             ar_take;
  logic             wr_take;
  logic [idx_w-1:0] rd_idx;
  logic [idx_w-1:0] wr_idx;

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem_q[i] = '0;
    end
  end

  // Stop taking requests only while a response sits unaccepted
  assign ar_ready = !(r_valid && !r_ready);
  assign aw_ready = !(b_valid && !b_ready);
  assign w_ready  = aw_ready;

  assign ar_take = ar_valid && ar_ready;
  assign wr_take = aw_valid && aw_ready && w_valid && w_ready;

  assign rd_idx = ar[`CACHE_OFFSET_W +: idx_w];
  assign wr_idx = aw[`CACHE_OFFSET_W +: idx_w];

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_take) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
      if (wr_take) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (ar_take) begin
      r_data <= mem_q[rd_idx];
    end
    if (wr_take) begin
      mem_q[wr_idx] <= axil_pkg::strb_merge(mem_q[wr_idx], w.data, w.strb);
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f vlog.f --top-module cache_system_tb -o cache_system_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cache_system_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// File: sim/cache_system_tb.sv
`timescale 1ns/10ps
`include "axil_macros.svh"

module cache_system_tb;

  localparam int timeout_cycles = 200;
  localparam int word_idx_w = $clog2(`MEM_WORDS);

  logic                 ACLK;
  logic                 ARESETn;
  logic                 ar_valid;
  logic                 ar_ready;
  axil_pkg::axil_addr_t ar;
  logic                 r_valid;
  logic                 r_ready;
  axil_pkg::axil_data_t r_data;
  logic                 aw_valid;
  logic                 aw_ready;
  axil_pkg::axil_addr_t aw;
  logic                 w_valid;
  logic                 w_ready;
  axil_pkg::axil_wr_t   w;
  logic                 b_valid;
  logic                 b_ready;

  integer      seed;
  int          mismatch_errs = 0;
  int          proto_errs = 0;
  int          timeout_errs = 0;
  logic [31:0] ref_mem [`MEM_WORDS];
  logic [31:0] exp_q [$];
  logic [31:0] exp_word;

  cache_system cache_system_i (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r_data   (r_data),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready)
  );

  initial begin
    ACLK = 1'b0;
    forever #5 ACLK = ~ACLK;
  end

  // Merges the strobed bytes into the model memory and returns the resulting word
  function automatic logic [31:0] ref_access(input logic [31:0] addr, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [word_idx_w-1:0] idx;
    idx = addr[`CACHE_OFFSET_W +: word_idx_w];
    for (int i = 0; i < `AXIL_STRB_W; i++) begin
      if (strb[i]) begin
        ref_mem[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
    return ref_mem[idx];
  endfunction

  task automatic report_and_finish();
    int total;
    total = mismatch_errs + proto_errs + timeout_errs;
    $display("Errors: %0d (mismatch %0d, protocol %0d, timeout %0d)", total, mismatch_errs,
             proto_errs, timeout_errs);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic note_timeout(input string what);
    timeout_errs++;
    $display("%0t: timed out after %0d cycles waiting for %s", $time, timeout_cycles, what);
  endtask

  // Returns 1 ns after the request transfer edge
  task automatic wait_accept(input bit is_read, input string name);
    int cycles;
    bit done;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < timeout_cycles) begin
      @(negedge ACLK);
      cycles++;
      done = is_read ? ar_ready : (aw_ready && w_ready);
      @(posedge ACLK);
      #1;
    end
    if (!done) begin
      note_timeout({name, " ready"});
    end
  endtask

  // Response wait with optional random back-pressure
  // An exp_lat of 0 skips the latency check
  task automatic wait_resp(input bit is_read, input bit stall, input int exp_lat,
                           input string name);
    int          cycles;
    bit          seen;
    bit          done;
    logic        vld;
    logic        rdy;
    logic [31:0] held;
    logic [31:0] rnd;
    cycles = 0;
    seen = 1'b0;
    done = 1'b0;
    held = '0;
    while (!done && cycles < timeout_cycles) begin
      rnd = $random(seed);
      rdy = !stall || (rnd[1:0] == 2'b00);
      if (is_read) begin
        r_ready = rdy;
      end else begin
        b_ready = rdy;
      end
      @(negedge ACLK);
      cycles++;
      vld = is_read ? r_valid : b_valid;
      assert (!ar_ready && !aw_ready && !w_ready) else begin
        proto_errs++;
        $display("%0t: request ready is high before the %s response transfer", $time, name);
      end
      if (seen) begin
        assert (vld && (!is_read || r_data == held)) else begin
          proto_errs++;
          $display("%0t: %s response changed while stalled", $time, name);
        end
      end else if (vld) begin
        seen = 1'b1;
        held = r_data;
        if (exp_lat > 0) begin
          assert (cycles == exp_lat) else begin
            proto_errs++;
            $display("%0t: %s valid came %0d cycles after the request, expected %0d",
                     $time, name, cycles, exp_lat);
          end
        end
      end
      done = vld && rdy;
      @(posedge ACLK);
      #1;
    end
    r_ready = 1'b0;
    b_ready = 1'b0;
    if (!done) begin
      note_timeout({name, " response"});
    end
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input bit stall, input int exp_lat);
    if (timeout_errs != 0) begin
      return;
    end
    aw_valid = 1'b1;
    aw = addr;
    w_valid = 1'b1;
    w.data = data;
    w.strb = strb;
    wait_accept(1'b0, "AW/W");
    aw_valid = 1'b0;
    w_valid = 1'b0;
    if (timeout_errs != 0) begin
      return;
    end
    void'(ref_access(addr, data, strb));
    wait_resp(1'b0, stall, exp_lat, "B");
  endtask

  task automatic do_read(input logic [31:0] addr, input bit stall, input int exp_lat);
    if (timeout_errs != 0) begin
      return;
    end
    ar_valid = 1'b1;
    ar = addr;
    wait_accept(1'b1, "AR");
    ar_valid = 1'b0;
    if (timeout_errs != 0) begin
      return;
    end
    exp_q.push_back(ref_access(addr, 32'h0, 4'h0));
    wait_resp(1'b1, stall, exp_lat, "R");
  endtask

  // Every R handshake is checked against the oldest expected word
  always @(negedge ACLK) begin
    if (ARESETn && r_valid && r_ready) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("%0t: read response arrived with no read outstanding", $time);
      end else begin
        exp_word = exp_q.pop_front();
        assert (r_data == exp_word) else begin
          mismatch_errs++;
          $display("mismatch at %0t: r_data expected %h actual %h", $time, exp_word, r_data);
        end
      end
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] data;
    seed = 32'hc991_c7d7;
    ARESETn = 1'b0;
    ar_valid = 1'b0;
    ar = '0;
    r_ready = 1'b0;
    aw_valid = 1'b0;
    aw = '0;
    w_valid = 1'b0;
    w = '0;
    b_ready = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (16) @(posedge ACLK);
    #1;
    ARESETn = 1'b1;

    @(negedge ACLK);
    assert (!r_valid && !b_valid && ar_ready && aw_ready && w_ready) else begin
      proto_errs++;
      $display("%0t: outputs after reset are not idle", $time);
    end
    @(posedge ACLK);
    #1;

    // Never written, so the fill brings back zero
    do_read(32'h0000_0020, 1'b0, 0);

    // Strobed write miss, then read hits
    do_write(32'h0000_0040, 32'hdead_beef, 4'b0101, 1'b0, 0);
    do_read(32'h0000_0040, 1'b0, 0);
    do_read(32'h0000_0040, 1'b0, 2);
    do_write(32'h0000_0040, 32'h1234_5678, 4'b1000, 1'b0, 1);
    do_read(32'h0000_0040, 1'b0, 2);

    // Same set with different tags forces write-back and refill
    do_write(32'h0000_0100, 32'haaaa_0001, 4'b1111, 1'b0, 0);
    do_write(32'h0000_0110, 32'hbbbb_0002, 4'b1111, 1'b0, 0);
    do_read(32'h0000_0100, 1'b0, 0);
    do_read(32'h0000_0110, 1'b0, 0);

    // Back-pressure on both response channels
    do_write(32'h0000_0104, 32'hcafe_f00d, 4'b0011, 1'b1, 0);
    do_read(32'h0000_0104, 1'b1, 0);
    do_read(32'h0000_0114, 1'b1, 0);
    do_write(32'h0000_0104, 32'h0bad_cafe, 4'b1100, 1'b1, 0);
    do_read(32'h0000_0104, 1'b1, 0);

    // 16 words over 4 sets keeps hits, misses and evictions all frequent
    repeat (300) begin
      rnd = $random(seed);
      data = $random(seed);
      addr = {26'h0, rnd[5:2], 2'b00};
      if (rnd[8]) begin
        do_write(addr, data, rnd[15:12], rnd[9], 0);
      end else begin
        do_read(addr, rnd[9], 0);
      end
    end

    assert (exp_q.size() == 0) else begin
      proto_errs++;
      $display("%0t: %0d reads never got a response", $time, exp_q.size());
    end
    report_and_finish();
  end

endmodule

// File: vlog.f
+incdir+common
common/axil_pkg.sv
cache/axil_req_hold.sv
cache/cache_store.sv
cache/cache_ctrl.sv
mem/axil_memory.sv
hdl/cache_system.sv
sim/cache_system_tb.sv
